/* tb.f */
+incdir+design
design/rv_core_pkg.sv
design/control_unit.sv
design/imm_gen.sv
design/reg_file.sv
design/id_stage.sv
design/ex_stage.sv
design/rv_core_top.sv
test/rv_core_chk.sv
test/rv_core_tb.sv

/* test/rv_core_tb.sv */
`include "rv_core_defs.svh"

module rv_core_tb
    import rv_core_pkg::*;
();

    localparam int CLK_PERIOD      = 10;
    localparam int RESET_CYCLES    = 3;
    localparam int DIRECTED_BOUND  = 64;
    localparam int RANDOM_COUNT    = 200;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + (DIRECTED_BOUND + RANDOM_COUNT) * 20;

    typedef struct packed {
        word_t       pc;
        logic        wb_en;
        reg_addr_t   rd;
        word_t       data;
        logic [31:0] due;
    } exp_t;

    logic      clk_i = 1'b0;
    logic      reset_i;
    logic      inst_valid_i;
    inst_t     inst_i;
    logic      retire_valid_o;
    word_t     retire_pc_o;
    logic      wb_en_o;
    reg_addr_t wb_rd_o;
    word_t     wb_data_o;

    integer      seed = 92371;
    logic [31:0] cycle_cnt = '0;
    word_t       model_pc = `RESET_PC;
    word_t       model_regs [32] = '{default: '0};
    exp_t        exp_q [$];
    string       name_q [$];

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

    rv_core_top dut_i (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .inst_valid_i   (inst_valid_i),
        .inst_i         (inst_i),
        .retire_valid_o (retire_valid_o),
        .retire_pc_o    (retire_pc_o),
        .wb_en_o        (wb_en_o),
        .wb_rd_o        (wb_rd_o),
        .wb_data_o      (wb_data_o)
    );

    bind rv_core_top rv_core_chk u_chk (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .retire_valid_i (retire_valid_o),
        .wb_en_i        (wb_en_o),
        .wb_rd_i        (wb_rd_o)
    );

    // instruction encoders
    function automatic inst_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                    logic [2:0] f3, reg_addr_t rd, logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic inst_t enc_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                    reg_addr_t rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic inst_t enc_b(logic [12:0] off, reg_addr_t rs2, reg_addr_t rs1,
                                    logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `OPC_BRANCH};
    endfunction

    function automatic inst_t enc_j(logic [20:0] off, reg_addr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, `OPC_JAL};
    endfunction

    // integer ALU of the ISA, alt picks SUB or SRA
    function automatic word_t alu_model(logic [2:0] f3, logic alt, word_t a, word_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // ISA model of one instruction, updates model pc and registers
    function automatic exp_t ref_step(inst_t inst);
        exp_t       e;
        logic [2:0] f3;
        reg_addr_t  rd;
        word_t      a;
        word_t      b;
        word_t      imm_i;
        word_t      imm_b;
        word_t      imm_j;
        word_t      imm_u;
        word_t      res;
        word_t      next;
        logic       wr;
        logic       taken;
        f3    = inst[14:12];
        rd    = inst[11:7];
        a     = model_regs[inst[19:15]];
        b     = model_regs[inst[24:20]];
        imm_i = {{20{inst[31]}}, inst[31:20]};
        imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        imm_u = {inst[31:12], 12'h000};
        res   = '0;
        wr    = 1'b0;
        next  = model_pc + 32'd4;
        case (inst[6:0])
            `OPC_OP: begin
                wr  = 1'b1;
                res = alu_model(f3, inst[30], a, b);
            end
            `OPC_OP_IMM: begin
                wr  = 1'b1;
                res = alu_model(f3, (f3 == 3'b101) && inst[30], a, imm_i);
            end
            `OPC_LUI: begin
                wr  = 1'b1;
                res = imm_u;
            end
            `OPC_AUIPC: begin
                wr  = 1'b1;
                res = model_pc + imm_u;
            end
            `OPC_JAL: begin
                wr   = 1'b1;
                res  = model_pc + 32'd4;
                next = model_pc + imm_j;
            end
            `OPC_JALR: begin
                wr   = 1'b1;
                res  = model_pc + 32'd4;
                next = (a + imm_i) & ~32'd1;
            end
            `OPC_BRANCH: begin
                case (f3)
                    3'b000:  taken = (a == b);
                    3'b001:  taken = (a != b);
                    3'b100:  taken = ($signed(a) < $signed(b));
                    3'b101:  taken = ($signed(a) >= $signed(b));
                    3'b110:  taken = (a < b);
                    3'b111:  taken = (a >= b);
                    default: taken = 1'b0;
                endcase
                if (taken) begin
                    next = model_pc + imm_b;
                end
            end
            default: ;
        endcase
        e.pc    = model_pc;
        e.wb_en = wr && (rd != '0);
        e.rd    = rd;
        e.data  = res;
        e.due   = '0;
        if (e.wb_en) begin
            model_regs[rd] = res;
        end
        model_pc = next;
        return e;
    endfunction

    task automatic check_value(string name, word_t expected, word_t actual);
        if (expected !== actual) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic push_inst(string name, inst_t inst);
        exp_t e;
        @(posedge clk_i);
        inst_valid_i <= 1'b1;
        inst_i       <= inst;
        e     = ref_step(inst);
        // retire shows up one cycle after the strobe
        e.due = cycle_cnt + 2;
        exp_q.push_back(e);
        name_q.push_back(name);
    endtask

    task automatic idle_cycle();
        @(posedge clk_i);
        inst_valid_i <= 1'b0;
        inst_i       <= '0;
    endtask

    function automatic inst_t random_inst();
        word_t raw;
        int    kind;
        raw  = $random(seed);
        kind = $unsigned($random(seed)) % 8;
        case (kind)
            0:       return {1'b0, raw[30], 5'b0, raw[24:7], `OPC_OP};
            1:       return {raw[31:7], `OPC_OP_IMM};
            2:       return {raw[31:7], `OPC_LUI};
            3:       return {raw[31:7], `OPC_AUIPC};
            4:       return enc_j({{9{raw[31]}}, raw[11:2], 2'b00}, raw[26:22]);
            5:       return {raw[31:15], 3'b000, raw[11:7], `OPC_JALR};
            6:       return enc_b({{3{raw[31]}}, raw[9:2], 2'b00}, raw[24:20], raw[19:15],
                                  raw[14:12]);
            // load, not supported
            default: return {raw[31:7], 7'b0000011};
        endcase
    endfunction

    task automatic run_directed();
        // registers read as zero out of reset
        push_inst("add of reset regs", enc_r(7'h00, 5'd2, 5'd1, `F3_ADD, 5'd5, `OPC_OP));
        push_inst("addi x1", enc_i(12'd100, 5'd0, `F3_ADD, 5'd1, `OPC_OP_IMM));
        // back to back, x1 comes from the bypass
        push_inst("addi dep", enc_i(12'hff9, 5'd1, `F3_ADD, 5'd2, `OPC_OP_IMM));
        push_inst("add dep", enc_r(7'h00, 5'd2, 5'd1, `F3_ADD, 5'd3, `OPC_OP));
        push_inst("sub", enc_r(7'h20, 5'd3, 5'd0, `F3_ADD, 5'd4, `OPC_OP));
        idle_cycle();
        push_inst("srai", enc_i(12'h403, 5'd4, `F3_SR, 5'd6, `OPC_OP_IMM));
        push_inst("srli", enc_i(12'h003, 5'd4, `F3_SR, 5'd7, `OPC_OP_IMM));
        push_inst("sra", enc_r(7'h20, 5'd1, 5'd4, `F3_SR, 5'd8, `OPC_OP));
        push_inst("srl", enc_r(7'h00, 5'd1, 5'd4, `F3_SR, 5'd9, `OPC_OP));
        push_inst("sll", enc_r(7'h00, 5'd1, 5'd3, `F3_SLL, 5'd10, `OPC_OP));
        push_inst("slli", enc_i(12'h005, 5'd3, `F3_SLL, 5'd10, `OPC_OP_IMM));
        push_inst("slt", enc_r(7'h00, 5'd1, 5'd4, `F3_SLT, 5'd11, `OPC_OP));
        push_inst("sltu", enc_r(7'h00, 5'd1, 5'd4, `F3_SLTU, 5'd12, `OPC_OP));
        push_inst("slti", enc_i(12'hfff, 5'd4, `F3_SLT, 5'd13, `OPC_OP_IMM));
        push_inst("sltiu", enc_i(12'hfff, 5'd1, `F3_SLTU, 5'd14, `OPC_OP_IMM));
        push_inst("xor", enc_r(7'h00, 5'd4, 5'd3, `F3_XOR, 5'd20, `OPC_OP));
        push_inst("or", enc_r(7'h00, 5'd2, 5'd1, `F3_OR, 5'd21, `OPC_OP));
        push_inst("and", enc_r(7'h00, 5'd4, 5'd3, `F3_AND, 5'd22, `OPC_OP));
        push_inst("xori", enc_i(12'h5a5, 5'd20, `F3_XOR, 5'd23, `OPC_OP_IMM));
        push_inst("ori", enc_i(12'h800, 5'd1, `F3_OR, 5'd24, `OPC_OP_IMM));
        push_inst("andi", enc_i(12'h0f0, 5'd4, `F3_AND, 5'd25, `OPC_OP_IMM));
        idle_cycle();
        push_inst("lui", {20'h12345, 5'd15, `OPC_LUI});
        push_inst("auipc", {20'h00010, 5'd16, `OPC_AUIPC});
        push_inst("write to x0", enc_i(12'd5, 5'd1, `F3_ADD, 5'd0, `OPC_OP_IMM));
        push_inst("store skipped", enc_r(7'h00, 5'd1, 5'd2, 3'b010, 5'd4, `OPC_STORE));
        // each kind once taken and once not taken
        push_inst("beq taken", enc_b(13'd16, 5'd1, 5'd1, 3'b000));
        push_inst("beq not taken", enc_b(13'd16, 5'd2, 5'd1, 3'b000));
        push_inst("bne taken", enc_b(13'h1ff8, 5'd2, 5'd1, 3'b001));
        push_inst("bne not taken", enc_b(13'd16, 5'd1, 5'd1, 3'b001));
        push_inst("blt taken", enc_b(13'd12, 5'd1, 5'd4, 3'b100));
        push_inst("blt not taken", enc_b(13'd12, 5'd4, 5'd1, 3'b100));
        push_inst("bge taken", enc_b(13'd20, 5'd4, 5'd1, 3'b101));
        push_inst("bge not taken", enc_b(13'd20, 5'd1, 5'd4, 3'b101));
        push_inst("bltu taken", enc_b(13'h1ff0, 5'd4, 5'd1, 3'b110));
        push_inst("bltu not taken", enc_b(13'd8, 5'd1, 5'd4, 3'b110));
        push_inst("bgeu taken", enc_b(13'd28, 5'd1, 5'd4, 3'b111));
        push_inst("bgeu not taken", enc_b(13'd28, 5'd4, 5'd1, 3'b111));
        push_inst("jal", enc_j(21'd24, 5'd17));
        // odd offset, bit 0 of the target is dropped
        push_inst("jalr", enc_i(12'd3, 5'd17, 3'b000, 5'd18, `OPC_JALR));
        push_inst("after jalr", enc_i(12'd0, 5'd18, `F3_ADD, 5'd19, `OPC_OP_IMM));
    endtask

    // compare each retire against the model at the falling edge
    always @(negedge clk_i) begin
        exp_t  cur;
        string name;
        if (!reset_i) begin
            if (exp_q.size() > 0 && exp_q[0].due == cycle_cnt) begin
                cur  = exp_q.pop_front();
                name = name_q.pop_front();
                check_value({name, " retire_valid"}, 32'd1, retire_valid_o);
                check_value({name, " retire_pc"}, cur.pc, retire_pc_o);
                check_value({name, " wb_en"}, cur.wb_en, wb_en_o);
                if (cur.wb_en) begin
                    check_value({name, " wb_rd"}, cur.rd, wb_rd_o);
                    check_value({name, " wb_data"}, cur.data, wb_data_o);
                end
            end else begin
                check_value("idle retire_valid", 32'd0, retire_valid_o);
            end
        end
    end

    initial begin
        wait (dut_i.u_chk.fail_seen);
        $display("a bound assertion on the DUT ports failed");
        $display("Simulation failed");
        $fatal(1, "assertion failure");
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired, the run hung before all instructions retired");
        $display("Simulation failed");
        $fatal(1, "watchdog timeout");
    end

    initial begin
        reset_i      = 1'b1;
        // a strobe under reset must neither retire nor move the pc
        inst_valid_i = 1'b1;
        inst_i       = enc_i(12'd1, 5'd0, `F3_ADD, 5'd1, `OPC_OP_IMM);
        repeat (RESET_CYCLES) @(posedge clk_i);
        reset_i      <= 1'b0;
        inst_valid_i <= 1'b0;
        inst_i       <= '0;
        run_directed();
        for (int i = 0; i < RANDOM_COUNT; i++) begin
            if ($unsigned($random(seed)) % 8 == 0) begin
                idle_cycle();
            end
            push_inst($sformatf("random %0d", i), random_inst());
        end
        repeat (3) idle_cycle();
        if (exp_q.size() == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("%0d pushed instructions never retired", exp_q.size());
            $display("Simulation failed");
            $fatal(1, "missing retires");
        end
    end

endmodule

/* test/rv_core_chk.sv */
`include "rv_core_defs.svh"

module rv_core_chk
    import rv_core_pkg::*;
(
    input logic      clk_i,
    input logic      reset_i,
    input logic      retire_valid_i,
    input logic      wb_en_i,
    input reg_addr_t wb_rd_i
);

    logic fail_seen = 1'b0;

    // id_ex valid is cleared by the reset edge
    a_idle_after_reset: assert property (@(posedge clk_i) reset_i |=> !retire_valid_i)
        else begin
            fail_seen = 1'b1;
            $error("retire_valid_o high in the cycle after reset");
        end

    // a write only comes with a retiring instruction
    a_wb_needs_retire: assert property (@(posedge clk_i) disable iff (reset_i)
        wb_en_i |-> retire_valid_i)
        else begin
            fail_seen = 1'b1;
            $error("wb_en_o high without retire_valid_o");
        end

    a_wb_not_x0: assert property (@(posedge clk_i) disable iff (reset_i)
        wb_en_i |-> (wb_rd_i != '0))
        else begin
            fail_seen = 1'b1;
            $error("wb_en_o high with wb_rd_o at x0");
        end

endmodule

/* design/rv_core_top.sv */
`include "rv_core_defs.svh"

module rv_core_top
    import rv_core_pkg::*;
(
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      inst_valid_i,
    input  inst_t     inst_i,
    output logic      retire_valid_o,
    output word_t     retire_pc_o,
    output logic      wb_en_o,
    output reg_addr_t wb_rd_o,
    output word_t     wb_data_o
);

    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;
    id_ex_t    id_ex;

    id_stage u_id (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .rs1_addr_o   (rs1_addr),
        .rs2_addr_o   (rs2_addr),
        .id_ex_o      (id_ex)
    );

    // write port doubles as the writeback outputs
    reg_file u_regs (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .wr_en_i    (wb_en_o),
        .wr_addr_i  (wb_rd_o),
        .wr_data_i  (wb_data_o),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    ex_stage u_ex (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .id_ex_i        (id_ex),
        .wr_en_o        (wb_en_o),
        .wr_addr_o      (wb_rd_o),
        .wr_data_o      (wb_data_o),
        .retire_valid_o (retire_valid_o),
        .retire_pc_o    (retire_pc_o)
    );

endmodule

/* design/ex_stage.sv */
`include "rv_core_defs.svh"

module ex_stage
    import rv_core_pkg::*;
(
    input  logic      clk_i,
    input  logic      reset_i,
    input  id_ex_t    id_ex_i,
    output logic      wr_en_o,
    output reg_addr_t wr_addr_o,
    output word_t     wr_data_o,
    output logic      retire_valid_o,
    output word_t     retire_pc_o
);

    id_ex_t                id_ex_q;
    word_t                 op_a;
    word_t                 op_b;
    word_t                 alu_result;
    logic [`SHAMT_W-1:0]   shamt;

    // id_ex register, only valid is cleared by reset
    always_ff @(posedge clk_i) begin
        id_ex_q <= id_ex_i;
        if (reset_i) begin
            id_ex_q.valid <= 1'b0;
        end
    end

    // operand select
    always_comb begin
        case (id_ex_q.ctrl.op_a_sel)
            OPA_RS1: op_a = id_ex_q.rs1_data;
            OPA_PC:  op_a = id_ex_q.pc;
            default: op_a = '0;
        endcase
    end

    always_comb begin
        case (id_ex_q.ctrl.op_b_sel)
            OPB_RS2:  op_b = id_ex_q.rs2_data;
            OPB_IMM:  op_b = id_ex_q.imm;
            default:  op_b = 32'd4;
        endcase
    end

    assign shamt = op_b[`SHAMT_W-1:0];

    always_comb begin
        case (id_ex_q.ctrl.alu_op)
            ALU_ADD:  alu_result = op_a + op_b;
            ALU_SUB:  alu_result = op_a - op_b;
            ALU_AND:  alu_result = op_a & op_b;
            ALU_OR:   alu_result = op_a | op_b;
            ALU_XOR:  alu_result = op_a ^ op_b;
            ALU_SLL:  alu_result = op_a << shamt;
            ALU_SRL:  alu_result = op_a >> shamt;
            ALU_SRA:  alu_result = word_t'($signed(op_a) >>> shamt);
            ALU_SLT: begin
                alu_result = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            end
            ALU_SLTU: begin
                alu_result = {{(`XLEN-1){1'b0}}, op_a < op_b};
            end
            default:  alu_result = op_b;
        endcase
    end

    // writeback port
    assign wr_en_o   = id_ex_q.valid && id_ex_q.ctrl.wr_en;
    assign wr_addr_o = id_ex_q.rd;
    assign wr_data_o = alu_result;

    // retire one cycle after the strobe
    assign retire_valid_o = id_ex_q.valid;
    assign retire_pc_o    = id_ex_q.pc;

endmodule

/* design/id_stage.sv */
`include "rv_core_defs.svh"

module id_stage
    import rv_core_pkg::*;
(
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      inst_valid_i,
    input  inst_t     inst_i,
    input  word_t     rs1_data_i,
    input  word_t     rs2_data_i,
    output reg_addr_t rs1_addr_o,
    output reg_addr_t rs2_addr_o,
    output id_ex_t    id_ex_o
);

    word_t     pc_q;
    word_t     pc_plus4;
    word_t     next_pc;
    word_t     imm;
    word_t     branch_offset;
    word_t     jalr_sum;
    word_t     target;
    reg_addr_t rd;
    ctrl_t     ctrl;
    logic      taken;

    assign rd         = inst_i[`FIELD_RD];
    assign rs1_addr_o = inst_i[`FIELD_RS1];
    assign rs2_addr_o = inst_i[`FIELD_RS2];

    control_unit u_control (
        .opcode_i     (inst_i[`FIELD_OPCODE]),
        .funct3_i     (inst_i[`FIELD_FUNCT3]),
        .funct7_alt_i (inst_i[`FUNCT7_ALT_BIT]),
        .ctrl_o       (ctrl)
    );

    imm_gen u_imm (
        .inst_i          (inst_i),
        .imm_o           (imm),
        .branch_offset_o (branch_offset)
    );

    // next pc
    assign pc_plus4 = pc_q + 32'd4;
    assign jalr_sum = rs1_data_i + imm;
    assign target   = (ctrl.branch_kind == BR_JALR) ? {jalr_sum[`XLEN-1:1], 1'b0}
                                                    : pc_q + branch_offset;

    always_comb begin
        case (ctrl.branch_kind)
            BR_JAL, BR_JALR: taken = 1'b1;
            BR_BEQ:  taken = (rs1_data_i == rs2_data_i);
            BR_BNE:  taken = (rs1_data_i != rs2_data_i);
            BR_BLT:  taken = ($signed(rs1_data_i) < $signed(rs2_data_i));
            BR_BGE:  taken = ($signed(rs1_data_i) >= $signed(rs2_data_i));
            BR_BLTU: taken = (rs1_data_i < rs2_data_i);
            BR_BGEU: taken = (rs1_data_i >= rs2_data_i);
            default: taken = 1'b0;
        endcase
    end

    assign next_pc = taken ? target : pc_plus4;

    // counter moves only on a strobe
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pc_q <= `RESET_PC;
        end else if (inst_valid_i) begin
            pc_q <= next_pc;
        end
    end

    always_comb begin
        id_ex_o.valid      = inst_valid_i;
        id_ex_o.pc         = pc_q;
        id_ex_o.rs1_data   = rs1_data_i;
        id_ex_o.rs2_data   = rs2_data_i;
        id_ex_o.imm        = imm;
        id_ex_o.rd         = rd;
        id_ex_o.ctrl       = ctrl;
        // a write to x0 is dropped here
        id_ex_o.ctrl.wr_en = ctrl.wr_en && (rd != '0);
    end

endmodule

/* design/reg_file.sv */
`include "rv_core_defs.svh"

module reg_file
    import rv_core_pkg::*;
(
    input  logic      clk_i,
    input  logic      reset_i,
    input  reg_addr_t rs1_addr_i,
    input  reg_addr_t rs2_addr_i,
    input  logic      wr_en_i,
    input  reg_addr_t wr_addr_i,
    input  word_t     wr_data_i,
    output word_t     rs1_data_o,
    output word_t     rs2_data_o
);

    word_t regs [`REG_COUNT];

    // x0 is never written so it stays zero after reset
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && wr_addr_i != '0) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // write-first: a same-cycle write wins over the stored value
    function automatic word_t read_port(reg_addr_t addr);
        if (wr_en_i && addr != '0 && wr_addr_i == addr) begin
            return wr_data_i;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs1_data_o = read_port(rs1_addr_i);
        rs2_data_o = read_port(rs2_addr_i);
    end

endmodule

/* design/imm_gen.sv */
`include "rv_core_defs.svh"

module imm_gen
    import rv_core_pkg::*;
(
    input  inst_t inst_i,
    output word_t imm_o,
    output word_t branch_offset_o
);

    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;

    // sign bit is always inst[31]
    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                    inst_i[11:8], 1'b0};
    assign imm_u = {inst_i[31:12], 12'b0};
    assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                    inst_i[30:21], 1'b0};

    always_comb begin
        case (inst_i[`FIELD_OPCODE])
            `OPC_OP_IMM, `OPC_JALR: imm_o = imm_i;
            `OPC_STORE:             imm_o = imm_s;
            `OPC_BRANCH:            imm_o = imm_b;
            `OPC_LUI, `OPC_AUIPC:   imm_o = imm_u;
            `OPC_JAL:               imm_o = imm_j;
            default:                imm_o = '0;
        endcase
    end

    // pc-relative offset for jal and conditional branches
    assign branch_offset_o = (inst_i[`FIELD_OPCODE] == `OPC_JAL) ? imm_j : imm_b;

endmodule

/* design/control_unit.sv */
`include "rv_core_defs.svh"

module control_unit
    import rv_core_pkg::*;
(
    input  logic [`OPCODE_W-1:0] opcode_i,
    input  logic [`FUNCT3_W-1:0] funct3_i,
    input  logic                 funct7_alt_i,
    output ctrl_t                ctrl_o
);

    alu_op_t alu_op;

    // shared funct3 decode for register and immediate forms
    always_comb begin
        case (funct3_i)
            `F3_ADD:  alu_op = (funct7_alt_i && opcode_i == `OPC_OP) ? ALU_SUB : ALU_ADD;
            `F3_SLL:  alu_op = ALU_SLL;
            `F3_SLT:  alu_op = ALU_SLT;
            `F3_SLTU: alu_op = ALU_SLTU;
            `F3_XOR:  alu_op = ALU_XOR;
            `F3_SR:   alu_op = funct7_alt_i ? ALU_SRA : ALU_SRL;
            `F3_OR:   alu_op = ALU_OR;
            default:  alu_op = ALU_AND;
        endcase
    end

    always_comb begin
        // unknown opcodes retire with no effect
        ctrl_o.alu_op      = ALU_PASS_B;
        ctrl_o.op_a_sel    = OPA_ZERO;
        ctrl_o.op_b_sel    = OPB_IMM;
        ctrl_o.wr_en       = 1'b0;
        ctrl_o.branch_kind = BR_NONE;
        case (opcode_i)
            `OPC_OP: begin
                ctrl_o.alu_op   = alu_op;
                ctrl_o.op_a_sel = OPA_RS1;
                ctrl_o.op_b_sel = OPB_RS2;
                ctrl_o.wr_en    = 1'b1;
            end
            `OPC_OP_IMM: begin
                ctrl_o.alu_op   = alu_op;
                ctrl_o.op_a_sel = OPA_RS1;
                ctrl_o.wr_en    = 1'b1;
            end
            `OPC_LUI: begin
                ctrl_o.alu_op = ALU_ADD;
                ctrl_o.wr_en  = 1'b1;
            end
            `OPC_AUIPC: begin
                ctrl_o.alu_op   = ALU_ADD;
                ctrl_o.op_a_sel = OPA_PC;
                ctrl_o.wr_en    = 1'b1;
            end
            `OPC_JAL, `OPC_JALR: begin
                // link value is pc+4
                ctrl_o.alu_op      = ALU_ADD;
                ctrl_o.op_a_sel    = OPA_PC;
                ctrl_o.op_b_sel    = OPB_FOUR;
                ctrl_o.wr_en       = 1'b1;
                ctrl_o.branch_kind = (opcode_i == `OPC_JAL) ? BR_JAL : BR_JALR;
            end
            `OPC_BRANCH: begin
                case (funct3_i)
                    3'b000:  ctrl_o.branch_kind = BR_BEQ;
                    3'b001:  ctrl_o.branch_kind = BR_BNE;
                    3'b100:  ctrl_o.branch_kind = BR_BLT;
                    3'b101:  ctrl_o.branch_kind = BR_BGE;
                    3'b110:  ctrl_o.branch_kind = BR_BLTU;
                    3'b111:  ctrl_o.branch_kind = BR_BGEU;
                    default: ctrl_o.branch_kind = BR_NONE;
                endcase
            end
            default: ;
        endcase
    end

endmodule

/* design/rv_core_pkg.sv */
`include "rv_core_defs.svh"

package rv_core_pkg;

    typedef logic [`XLEN-1:0]   word_t;
    typedef logic [`XLEN-1:0]   inst_t;
    typedef logic [`REG_AW-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS_B
    } alu_op_t;

    typedef enum logic [1:0] {
        OPA_RS1,
        OPA_PC,
        OPA_ZERO
    } op_a_sel_t;

    typedef enum logic [1:0] {
        OPB_RS2,
        OPB_IMM,
        OPB_FOUR
    } op_b_sel_t;

    // both jumps and the six conditional kinds
    typedef enum logic [3:0] {
        BR_NONE,
        BR_JAL,
        BR_JALR,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU
    } branch_kind_t;

    typedef struct packed {
        alu_op_t      alu_op;
        op_a_sel_t    op_a_sel;
        op_b_sel_t    op_b_sel;
        logic         wr_en;
        branch_kind_t branch_kind;
    } ctrl_t;

    // decode to execute payload
    typedef struct packed {
        logic      valid;
        word_t     pc;
        word_t     rs1_data;
        word_t     rs2_data;
        word_t     imm;
        reg_addr_t rd;
        ctrl_t     ctrl;
    } id_ex_t;

endpackage

/* design/rv_core_defs.svh */
`ifndef RV_CORE_DEFS_SVH
`define RV_CORE_DEFS_SVH

// data path widths
`define XLEN            32
`define REG_AW          5
`define REG_COUNT       32
`define SHAMT_W         5
`define OPCODE_W        7
`define FUNCT3_W        3

// counter value out of reset
`define RESET_PC        32'h0000_0000

// instruction field positions
`define FIELD_OPCODE    6:0
`define FIELD_RD        11:7
`define FIELD_FUNCT3    14:12
`define FIELD_RS1       19:15
`define FIELD_RS2       24:20
`define FUNCT7_ALT_BIT  30

// major opcodes
`define OPC_OP          7'b0110011
`define OPC_OP_IMM      7'b0010011
`define OPC_LUI         7'b0110111
`define OPC_AUIPC       7'b0010111
`define OPC_JAL         7'b1101111
`define OPC_JALR        7'b1100111
`define OPC_BRANCH      7'b1100011
`define OPC_STORE       7'b0100011

// funct3 for OP and OP-IMM
`define F3_ADD          3'b000
`define F3_SLL          3'b001
`define F3_SLT          3'b010
`define F3_SLTU         3'b011
`define F3_XOR          3'b100
`define F3_SR           3'b101
`define F3_OR           3'b110
`define F3_AND          3'b111

`endif
